// File: Makefile
# Verilator build and run of the EX/MEM/WB pipe testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP ?= tb_mips_exmem
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/mips_alu.sv
// ********************
// execute stage ALU, purely combinational
// ********************
`timescale 1ns/1ps

module mips_alu (
   input mips_pkg::alu_op_e op,
   input mips_pkg::word_t a,
   input mips_pkg::word_t b,
   output mips_pkg::word_t y
);

   import mips_pkg::*;

   // shift amount for sll/srl/sra comes from the immediate field in b
   logic [4:0] shamt_imm;
   // variable shifts use low bits of a
   logic [4:0] shamt_var;
   logic lt_signed;
   logic lt_unsigned;

   assign shamt_imm = b[SHAMT_MSB:SHAMT_LSB];
   assign shamt_var = a[4:0];
   assign lt_signed = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb
   begin
      y = '0;
      case (op)
         ALU_ADD: y = a + b;
         ALU_SUB: y = a - b;
         // immediate shifts act on a
         ALU_SLL: y = a << shamt_imm;
         ALU_SRL: y = a >> shamt_imm;
         ALU_SRA: y = word_t'($signed(a) >>> shamt_imm);
         // variable shifts act on b
         ALU_SLLV: y = b << shamt_var;
         ALU_SRLV: y = b >> shamt_var;
         ALU_SRAV: y = word_t'($signed(b) >>> shamt_var);
         ALU_AND: y = a & b;
         ALU_OR: y = a | b;
         ALU_XOR: y = a ^ b;
         ALU_NOR: y = ~(a | b);
         // compares give 0 or 1 in bit 0
         ALU_SLT: y = {{(WORD_W-1){1'b0}}, lt_signed};
         ALU_SLTU: y = {{(WORD_W-1){1'b0}}, lt_unsigned};
         default: y = '0;
      endcase
   end

endmodule

// File: hw/mips_exmem_pipe.sv
// ********************
// EX, MEM and WB stages with stage registers
// and writeback select
// ********************
`timescale 1ns/1ps

module mips_exmem_pipe (
   input logic clk,
   input logic rst_b,
   input mips_pkg::issue_s issue,
   output mips_pkg::mem_addr_t mem_addr,
   output mips_pkg::word_t mem_wdata,
   output mips_pkg::byte_en_t mem_be,
   input mips_pkg::word_t mem_rdata,
   output mips_pkg::result_s result
);

   import mips_pkg::*;

   // stage registers
   issue_s ex_q;
   mem_stage_s mem_q;
   result_s wb_q;

   word_t alu_y;
   word_t load_value;
   word_t wb_value;
   logic [1:0] byte_off;
   logic store_active;
   load_sel_e ld_sel;
   store_sel_e st_sel;

   // EX stage
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         ex_q <= '0;
      else
         ex_q <= issue;
   end

   mips_alu alu_i (
      .op (ex_q.alu_op),
      .a (ex_q.op_a),
      .b (ex_q.op_b),
      .y (alu_y)
   );

   // MEM stage where the alu result doubles as the byte address
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         mem_q <= '0;
      end
      else
      begin
         mem_q.valid <= ex_q.valid;
         mem_q.dest <= ex_q.dest;
         mem_q.mem_kind <= ex_q.mem_kind;
         mem_q.mem_sel <= ex_q.mem_sel;
         mem_q.imm16 <= ex_q.imm16;
         mem_q.alu_result <= alu_y;
         mem_q.store_data <= ex_q.store_data;
      end
   end

   assign mem_addr = mem_q.alu_result[WORD_W-1:2];
   assign byte_off = mem_q.alu_result[1:0];
   assign store_active = mem_q.valid && (mem_q.mem_kind == MEM_STORE);

   // decode the shared select field according to mem_kind
   always_comb
   begin
      ld_sel = LD_LW;
      st_sel = ST_SW;
      if (mem_q.mem_kind == MEM_LOAD)
         ld_sel = mem_q.mem_sel.ld;
      if (mem_q.mem_kind == MEM_STORE)
         st_sel = mem_q.mem_sel.st;
   end

   mips_store_align store_align_i (
      .valid (store_active),
      .sel (st_sel),
      .byte_off (byte_off),
      .data (mem_q.store_data),
      .wdata (mem_wdata),
      .be (mem_be)
   );

   // mem_rdata is combinational, so the load completes in MEM
   mips_load_align load_align_i (
      .sel (ld_sel),
      .byte_off (byte_off),
      .imm16 (mem_q.imm16),
      .rdata (mem_rdata),
      .value (load_value)
   );

   assign wb_value = (mem_q.mem_kind == MEM_LOAD) ? load_value : mem_q.alu_result;

   // WB stage that drops stores since they write no register
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         wb_q <= '0;
      end
      else
      begin
         wb_q.valid <= mem_q.valid && (mem_q.mem_kind != MEM_STORE);
         wb_q.dest <= mem_q.dest;
         wb_q.value <= wb_value;
      end
   end

   assign result = wb_q;

   a_result_valid_known: assert property (@(posedge clk) disable iff (!rst_b)
      !$isunknown(result.valid));

   // issue edge plus three is where the result would appear
   a_store_no_result: assert property (@(posedge clk) disable iff (!rst_b)
      (issue.valid && issue.mem_kind == MEM_STORE) |-> ##3 !result.valid);

   // the unused kind code 11 would mark an op as both load and store
   a_kind_single: assert property (@(posedge clk) disable iff (!rst_b)
      mem_q.valid |-> (mem_q.mem_kind inside {MEM_NONE, MEM_LOAD, MEM_STORE}));

endmodule

// File: hw/mips_load_align.sv
// ********************
// load lane extract, sign/zero extend, lui
// ********************
`timescale 1ns/1ps

module mips_load_align (
   input mips_pkg::load_sel_e sel,
   input logic [1:0] byte_off,
   input logic [15:0] imm16,
   input mips_pkg::word_t rdata,
   output mips_pkg::word_t value
);

   import mips_pkg::*;

   // read word moved down so the addressed lane lands in bits 7:0
   word_t lane_data;

   // lane k is at bits 8k+7:8k
   assign lane_data = rdata >> {byte_off, 3'b000};

   always_comb
   begin
      value = '0;
      case (sel)
         // upper half from the immediate, no memory data
         LD_LUI: value = {imm16, 16'h0000};
         LD_LB: value = {{24{lane_data[7]}}, lane_data[7:0]};
         LD_LH: value = {{16{lane_data[15]}}, lane_data[15:0]};
         // word access is aligned, take it unshifted
         LD_LW: value = rdata;
         LD_LBU: value = {24'h000000, lane_data[7:0]};
         LD_LHU: value = {16'h0000, lane_data[15:0]};
         default: value = '0;
      endcase
   end

endmodule

// File: hw/mips_pkg.sv
// ********************
// shared widths, opcode enums, memory select union
// and the EX/MEM/WB stage structs
// ********************
package mips_pkg;

   // word geometry
   localparam int WORD_W = 32;
   localparam int LANES = WORD_W / 8;

   // immediate shift amount sits in bits 10:6 of operand b
   localparam int SHAMT_LSB = 6;
   localparam int SHAMT_MSB = 10;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [4:0] reg_idx_t;
   // word address, byte address bits 31:2
   typedef logic [WORD_W-3:0] mem_addr_t;
   // bit k enables lane k, little-endian
   typedef logic [LANES-1:0] byte_en_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_SLLV, ALU_SRLV, ALU_SRAV,
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      MEM_NONE = 2'd0,
      MEM_LOAD = 2'd1,
      MEM_STORE = 2'd2
   } mem_kind_e;

   // lui rides on the load path so it shares the writeback mux
   typedef enum logic [2:0] {
      LD_LUI = 3'd0,
      LD_LB = 3'd1,
      LD_LH = 3'd2,
      LD_LW = 3'd3,
      LD_LBU = 3'd4,
      LD_LHU = 3'd5
   } load_sel_e;

   // same width as load_sel_e so both fit one union field
   typedef enum logic [2:0] {
      ST_SB = 3'd0,
      ST_SH = 3'd1,
      ST_SW = 3'd2
   } store_sel_e;

   // one field, decoded as load or store select by mem_kind
   typedef union packed {
      load_sel_e ld;
      store_sel_e st;
   } mem_sel_u;

   // decoded op with operands already read
   typedef struct packed {
      logic valid;
      reg_idx_t dest;
      alu_op_e alu_op;
      word_t op_a;
      word_t op_b;
      mem_kind_e mem_kind;
      mem_sel_u mem_sel;
      logic [15:0] imm16;
      word_t store_data;
   } issue_s;

   typedef struct packed {
      logic valid;
      reg_idx_t dest;
      mem_kind_e mem_kind;
      mem_sel_u mem_sel;
      logic [15:0] imm16;
      word_t alu_result;
      word_t store_data;
   } mem_stage_s;

   typedef struct packed {
      logic valid;
      reg_idx_t dest;
      word_t value;
   } result_s;

endpackage

// File: hw/mips_store_align.sv
// ********************
// store lane placement and byte enables
// ********************
`timescale 1ns/1ps

module mips_store_align (
   input logic valid,
   input mips_pkg::store_sel_e sel,
   input logic [1:0] byte_off,
   input mips_pkg::word_t data,
   output mips_pkg::word_t wdata,
   output mips_pkg::byte_en_t be
);

   import mips_pkg::*;

   // lane shift in bits
   logic [4:0] bit_off;

   assign bit_off = {byte_off, 3'b000};

   always_comb
   begin
      wdata = data;
      be = '0;
      case (sel)
         // low byte into lane byte_off
         ST_SB:
         begin
            wdata = {24'h000000, data[7:0]} << bit_off;
            be = byte_en_t'(1) << byte_off;
         end
         // low half into lanes byte_off and byte_off+1
         ST_SH:
         begin
            wdata = {16'h0000, data[15:0]} << bit_off;
            be = byte_en_t'(3) << byte_off;
         end
         ST_SW: be = {LANES{1'b1}};
         default: be = '0;
      endcase
      // no write unless a store is in MEM
      if (!valid)
         be = '0;
   end

   // no exception path, so a misaligned store must never arrive
   a_store_aligned: assert final (!valid
      || ((sel != ST_SH || !byte_off[0]) && (sel != ST_SW || byte_off == 2'd0)))
      else $error("misaligned store sel=%0d off=%0d", sel, byte_off);

endmodule

// File: include/tb_vectors.svh
// ********************
// directed rows, each an issue with its result or read-back word
// ********************
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic fill_directed_rows();
   // immediate shifts move a by b[10:6], variable shifts move b by a[4:0]
   rows.push_back(alu_row(ALU_SLL, 32'h0000_00f1, 32'h0000_0100, 5'd1, 32'h0000_0f10));
   rows.push_back(alu_row(ALU_SRL, 32'h8000_0f00, 32'h0000_0200, 5'd2, 32'h0080_000f));
   rows.push_back(alu_row(ALU_SRA, 32'h8000_0f00, 32'h0000_0200, 5'd3, 32'hff80_000f));
   rows.push_back(alu_row(ALU_SRA, 32'h8000_0000, 32'h0000_07c0, 5'd4, 32'hffff_ffff));
   rows.push_back(alu_row(ALU_SLLV, 32'h0000_0024, 32'h0000_00f1, 5'd5, 32'h0000_0f10));
   rows.push_back(alu_row(ALU_SRLV, 32'h0000_0003, 32'hf000_0008, 5'd6, 32'h1e00_0001));
   rows.push_back(alu_row(ALU_SRAV, 32'hffff_ffe3, 32'hf000_0008, 5'd7, 32'hfe00_0001));
   rows.push_back(bubble_row());
   // boundary operands, sign bit and all ones
   rows.push_back(alu_row(ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd8, 32'h8000_0000));
   rows.push_back(alu_row(ALU_SUB, 32'h0000_0000, 32'h0000_0001, 5'd9, 32'hffff_ffff));
   rows.push_back(alu_row(ALU_SLT, 32'h8000_0000, 32'h0000_0001, 5'd10, 32'h0000_0001));
   rows.push_back(alu_row(ALU_SLTU, 32'h8000_0000, 32'h0000_0001, 5'd11, 32'h0000_0000));
   rows.push_back(alu_row(ALU_SLTU, 32'h0000_0001, 32'hffff_ffff, 5'd12, 32'h0000_0001));
   rows.push_back(alu_row(ALU_NOR, 32'hffff_0000, 32'h0000_00ff, 5'd13, 32'h0000_ff00));
   rows.push_back(alu_row(ALU_XOR, 32'hffff_ffff, 32'h1234_5678, 5'd14, 32'hedcb_a987));
   rows.push_back(alu_row(ALU_AND, 32'hf0f0_f0f0, 32'h3c3c_3c3c, 5'd15, 32'h3030_3030));
   rows.push_back(alu_row(ALU_OR, 32'h8000_0000, 32'h0000_0001, 5'd16, 32'h8000_0001));
   rows.push_back(bubble_row());
   // stores into word 0x40, each read back at once with lw
   rows.push_back(store_row(ST_SW, 32'h0000_0040, 32'h8a7b_6c5d));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd17, 32'h8a7b_6c5d));
   rows.push_back(store_row(ST_SB, 32'h0000_0040, 32'h1111_11e1));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd18, 32'h8a7b_6ce1));
   rows.push_back(store_row(ST_SB, 32'h0000_0041, 32'h2222_22e2));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd19, 32'h8a7b_e2e1));
   rows.push_back(store_row(ST_SB, 32'h0000_0042, 32'h3333_33e3));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd20, 32'h8ae3_e2e1));
   rows.push_back(store_row(ST_SB, 32'h0000_0043, 32'h4444_44e4));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd21, 32'he4e3_e2e1));
   rows.push_back(store_row(ST_SH, 32'h0000_0040, 32'h5555_1357));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd22, 32'he4e3_1357));
   rows.push_back(store_row(ST_SH, 32'h0000_0042, 32'haaaa_9bdf));
   rows.push_back(load_row(LD_LW, 32'h0000_0040, 5'd23, 32'h9bdf_1357));
   rows.push_back(bubble_row());
   // word now 9b df 13 57 from lane 3 down to lane 0
   rows.push_back(load_row(LD_LB, 32'h0000_0040, 5'd24, 32'h0000_0057));
   rows.push_back(load_row(LD_LB, 32'h0000_0041, 5'd25, 32'h0000_0013));
   rows.push_back(load_row(LD_LB, 32'h0000_0042, 5'd26, 32'hffff_ffdf));
   rows.push_back(load_row(LD_LB, 32'h0000_0043, 5'd27, 32'hffff_ff9b));
   rows.push_back(load_row(LD_LBU, 32'h0000_0040, 5'd28, 32'h0000_0057));
   rows.push_back(load_row(LD_LBU, 32'h0000_0041, 5'd29, 32'h0000_0013));
   rows.push_back(load_row(LD_LBU, 32'h0000_0042, 5'd30, 32'h0000_00df));
   rows.push_back(load_row(LD_LBU, 32'h0000_0043, 5'd31, 32'h0000_009b));
   rows.push_back(load_row(LD_LH, 32'h0000_0040, 5'd1, 32'h0000_1357));
   rows.push_back(load_row(LD_LH, 32'h0000_0042, 5'd2, 32'hffff_9bdf));
   rows.push_back(load_row(LD_LHU, 32'h0000_0040, 5'd3, 32'h0000_1357));
   rows.push_back(load_row(LD_LHU, 32'h0000_0042, 5'd4, 32'h0000_9bdf));
   rows.push_back(lui_row(16'hbeef, 5'd5, 32'hbeef_0000));
   rows.push_back(lui_row(16'h7f01, 5'd6, 32'h7f01_0000));
   rows.push_back(bubble_row());
endtask

`endif

// File: test/tb_mips_exmem.sv
// ********************
// EX/MEM/WB pipe testbench: clock, reset, LFSR, memory model,
// row table loop and in-order result checker
// ********************
`timescale 1ns/1ps

module tb_mips_exmem;

   import mips_pkg::*;

   localparam int MEM_WORDS = 64;
   localparam int RANDOM_ROWS = 28;
   localparam int DRAIN_TIMEOUT = 20;

   // one table row, the issue and what it should produce
   typedef struct packed {
      issue_s issue;
      logic has_result;
      word_t exp_value;
   } vec_s;

   // outstanding result and the edge count at which it must show
   typedef struct {
      reg_idx_t dest;
      word_t value;
      int due;
   } exp_s;

   logic clk;
   logic rst_b;
   issue_s issue;
   mem_addr_t mem_addr;
   word_t mem_wdata;
   byte_en_t mem_be;
   word_t mem_rdata;
   result_s result;

   word_t mem [MEM_WORDS];
   logic [31:0] lfsr_state;
   int edge_count = 0;
   logic started;
   vec_s rows [$];
   exp_s expect_q [$];

   mips_exmem_pipe dut_i (
      .clk (clk),
      .rst_b (rst_b),
      .issue (issue),
      .mem_addr (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_be (mem_be),
      .mem_rdata (mem_rdata),
      .result (result)
   );

   // 20 ns period
   always #10 clk = ~clk;

   always @(posedge clk)
      edge_count <= edge_count + 1;

   // memory answers in the same cycle, writes land lane by lane at the edge
   assign mem_rdata = mem[mem_addr[5:0]];

   always @(posedge clk)
   begin
      for (int k = 0; k < 4; k++)
         if (mem_be[k])
            mem[mem_addr[5:0]][8*k +: 8] <= mem_wdata[8*k +: 8];
   end

   task automatic value_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic stop_on_error(string what);
      $display("ERROR t=%0t %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "%s", what);
   endtask

   // galois LFSR, x^32+x^22+x^2+x+1, one step per bit handed out
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      return out;
   endfunction

   function automatic word_t rand_bits(int n);
      word_t w;
      w = '0;
      for (int i = 0; i < n; i++)
         w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   // reference ALU, shifts done one bit at a time
   function automatic word_t expected_alu(alu_op_e op, word_t a, word_t b);
      word_t r;
      int n;
      r = a;
      n = int'(b[10:6]);
      if (op inside {ALU_SLLV, ALU_SRLV, ALU_SRAV})
      begin
         r = b;
         n = int'(a[4:0]);
      end
      case (op)
         ALU_ADD: r = a + b;
         ALU_SUB: r = a + ~b + 32'd1;
         ALU_SLL, ALU_SLLV: repeat (n) r = {r[30:0], 1'b0};
         ALU_SRL, ALU_SRLV: repeat (n) r = {1'b0, r[31:1]};
         ALU_SRA, ALU_SRAV: repeat (n) r = {r[31], r[31:1]};
         ALU_AND: r = a & b;
         ALU_OR: r = a | b;
         ALU_XOR: r = a ^ b;
         ALU_NOR: r = ~(a | b);
         // differing signs decide signed order by the sign of a
         ALU_SLT: r = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
         ALU_SLTU: r = {31'd0, a < b};
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic vec_s alu_row(alu_op_e op, word_t a, word_t b, reg_idx_t dest,
                                    word_t exp_value);
      vec_s r;
      r = '0;
      r.issue.valid = 1'b1;
      r.issue.dest = dest;
      r.issue.alu_op = op;
      r.issue.op_a = a;
      r.issue.op_b = b;
      r.issue.mem_kind = MEM_NONE;
      r.has_result = 1'b1;
      r.exp_value = exp_value;
      return r;
   endfunction

   // address is formed by add with b zero
   function automatic vec_s store_row(store_sel_e sel, word_t addr, word_t data);
      vec_s r;
      r = alu_row(ALU_ADD, addr, 32'h0, 5'd0, 32'h0);
      r.issue.mem_kind = MEM_STORE;
      r.issue.mem_sel.st = sel;
      r.issue.store_data = data;
      r.has_result = 1'b0;
      return r;
   endfunction

   function automatic vec_s load_row(load_sel_e sel, word_t addr, reg_idx_t dest,
                                     word_t exp_value);
      vec_s r;
      r = alu_row(ALU_ADD, addr, 32'h0, dest, exp_value);
      r.issue.mem_kind = MEM_LOAD;
      r.issue.mem_sel.ld = sel;
      return r;
   endfunction

   function automatic vec_s lui_row(logic [15:0] imm, reg_idx_t dest, word_t exp_value);
      vec_s r;
      r = load_row(LD_LUI, 32'h0, dest, exp_value);
      r.issue.imm16 = imm;
      return r;
   endfunction

   function automatic vec_s bubble_row();
      vec_s r;
      r = '0;
      return r;
   endfunction

`include "tb_vectors.svh"

   task automatic add_random_rows();
      alu_op_e op;
      word_t a;
      word_t b;
      reg_idx_t d;
      for (int i = 0; i < RANDOM_ROWS; i++)
      begin
         op = alu_op_e'(4'(i % 14));
         a = rand_bits(32);
         b = rand_bits(32);
         d = reg_idx_t'(rand_bits(5));
         rows.push_back(alu_row(op, a, b, d, expected_alu(op, a, b)));
         // occasional bubble keeps the burst uneven
         if (lfsr_bit())
            rows.push_back(bubble_row());
      end
   endtask

   // sampled mid-cycle where the registered outputs are settled
   always @(negedge clk)
   begin
      exp_s head;
      if (!started)
      begin
         assert (result.valid === 1'b0)
            else value_mismatch("result.valid", 32'h0, 32'(result.valid));
         assert (mem_be === 4'b0000)
            else value_mismatch("mem_be", 32'h0, 32'(mem_be));
      end
      else if (result.valid === 1'b1)
      begin
         assert (expect_q.size() != 0)
            else stop_on_error("result valid with no operation outstanding");
         head = expect_q.pop_front();
         assert (edge_count == head.due)
            else value_mismatch("result latency edge", 32'(head.due), 32'(edge_count));
         assert (result.dest === head.dest)
            else value_mismatch("result.dest", 32'(head.dest), 32'(result.dest));
         assert (result.value === head.value)
            else value_mismatch("result.value", head.value, result.value);
      end
      else
      begin
         assert (expect_q.size() == 0 || edge_count < expect_q[0].due)
            else stop_on_error("expected result did not appear on time");
      end
   end

   initial
   begin
      int wait_cycles;
      exp_s e;
      clk = 1'b0;
      rst_b = 1'b0;
      issue = '0;
      started = 1'b0;
      lfsr_state = 32'h0195_d9ac;
      // fill depends on every address bit
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] <= (32'(i) * 32'h0104_0811) ^ 32'h5a3c_c3a5;
      fill_directed_rows();
      add_random_rows();

      repeat (8) @(posedge clk);
      #2;
      rst_b = 1'b1;
      // idle cycles after reset, still checked for quiet outputs
      repeat (3) @(posedge clk);

      // row driven 2 ns after edge n is captured at n+1 and shows after n+3
      foreach (rows[i])
      begin
         @(posedge clk);
         #2;
         started = 1'b1;
         issue = rows[i].issue;
         if (rows[i].issue.valid && rows[i].has_result)
         begin
            e.dest = rows[i].issue.dest;
            e.value = rows[i].exp_value;
            e.due = edge_count + 3;
            expect_q.push_back(e);
         end
      end
      @(posedge clk);
      #2;
      issue = '0;

      for (wait_cycles = 0; wait_cycles < DRAIN_TIMEOUT && expect_q.size() != 0;
           wait_cycles++)
         @(posedge clk);
      @(negedge clk);

      if (expect_q.size() == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
         stop_on_error("timeout waiting for outstanding results");
   end

endmodule

// File: verilog.f
+incdir+include
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_load_align.sv
hw/mips_store_align.sv
hw/mips_exmem_pipe.sv
test/tb_mips_exmem.sv
